//--- vlog.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_ctrl.sv
hdl/dcache_array.sv
hdl/mshr_queue.sv
hdl/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

//--- verif/dcache_tb.sv
// testbench for the dcache with random loads and stores against a byte-level reference
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_BLOCKS = 32;
    localparam int NUM_OPS    = 2000;
    localparam int MAX_CYCLES = NUM_OPS * 40;
    localparam int CACHED_MAX = `DCACHE_NUM_SETS * `DCACHE_NUM_WAYS + `DCACHE_MSHR_DEPTH;

    logic       clock;
    logic       reset;
    load_req_t  load_req;
    store_req_t store_req;
    load_resp_t load_resp;
    logic       store_accepted;
    fill_t      fill;
    mem_req_t   mem_req;
    logic       mem_accepted;
    mem_tag_t   mem_tag;
    mem_resp_t  mem_resp;

    integer      seed = 32'h5abc_f27d;
    int          cycles = 0;
    logic [7:0]  ref_bytes [NUM_BLOCKS][BLOCK_BYTES];
    logic        mem_fresh [NUM_BLOCKS];
    mshr_idx_t   pend_idx [$];
    int          pend_addr [$];
    mshr_idx_t   next_alloc;
    logic        op_done;
    block_mask_t last_mask;

    dcache_top dut (.*);

    dcache_mem_model #(.NUM_BLOCKS(NUM_BLOCKS), .LATENCY(12)) mem (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    ////////////////////
    // failure reporting

    task automatic abort_run(string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic wrong_value(string name, logic [63:0] got, logic [63:0] exp);
        abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    ////////////////////
    // reference model

    function automatic block_t ref_block(int a);
        block_t b;
        for (int k = 0; k < BLOCK_BYTES; k++) begin
            b[k/4][8*(k%4) +: 8] = ref_bytes[a][k];
        end
        return b;
    endfunction

    // bit enables from a byte mask
    function automatic logic [63:0] byte_enables(block_mask_t m);
        logic [63:0] e;
        for (int k = 0; k < BLOCK_BYTES; k++) begin
            e[8*k +: 8] = {8{m[k]}};
        end
        return e;
    endfunction

    task automatic apply_store(store_req_t st);
        int a;
        int w;
        a = int'(st.address.block.block_addr);
        w = int'(st.address.block.word_idx);
        for (int b = 0; b < 4; b++) begin
            if (st.mask[b]) begin
                ref_bytes[a][4*w + b] = st.data[8*b +: 8];
            end
        end
    endtask

    task automatic outputs_idle();
        assert (!load_resp.valid && !store_accepted && !fill.valid && !mem_req.valid)
            else abort_run("an output strobe was active during or just after reset");
    endtask

    task automatic verify_load();
        int          a;
        int          pos;
        logic [63:0] en;
        a   = int'(load_req.address.block.block_addr);
        en  = byte_enables(load_resp.mask);
        pos = -1;
        assert ((load_resp.block & en) == (ref_block(a) & en))
            else wrong_value("load_resp.block", load_resp.block & en, ref_block(a) & en);
        // partial data only comes from the pending entry of that block
        if (load_resp.mask != '1) begin
            foreach (pend_addr[i]) begin
                if (pend_addr[i] == a) begin
                    pos = i;
                end
            end
            assert (pos >= 0 && pend_idx[pos] == load_resp.mshr_idx)
                else abort_run("partial load data does not name the pending MSHR entry");
        end
    endtask

    task automatic verify_fill();
        assert (pend_idx.size() > 0 && pend_idx[0] == fill.mshr_idx)
            else abort_run("fill names an MSHR entry that is not the oldest pending miss");
        assert (fill.block == ref_block(pend_addr[0]))
            else wrong_value("fill.block", fill.block, ref_block(pend_addr[0]));
        void'(pend_idx.pop_front());
        void'(pend_addr.pop_front());
    endtask

    ////////////////////
    // stimulus

    task automatic drive_idle();
        load_req  = '0;
        store_req = '0;
    endtask

    // hold one request until it is served
    task automatic run_op(logic is_store, dcache_addr_t addr, word_t data, byte_mask_t mask);
        drive_idle();
        if (is_store) begin
            store_req.valid   = 1'b1;
            store_req.address = addr;
            store_req.data    = data;
            store_req.mask    = mask;
        end else begin
            load_req.valid   = 1'b1;
            load_req.address = addr;
        end
        op_done = 1'b0;
        do begin
            @(negedge clock);
        end while (!op_done);
        drive_idle();
    endtask

    // responses are taken at the rising edge before any state moves
    always @(posedge clock) begin
        int a;
        int want;
        if (!reset) begin
            assert (!(load_resp.valid && !load_req.valid) && !(store_accepted && !store_req.valid))
                else abort_run("a response strobe came with no request held");
            if (store_accepted) begin
                apply_store(store_req);
                mem_fresh[int'(store_req.address.block.block_addr)] = 1'b0;
            end
            if (mem_req.valid && mem_accepted) begin
                a = int'(mem_req.block_addr);
                if (mem_req.write) begin
                    assert (mem_req.block == ref_block(a))
                        else wrong_value("mem_req.block", mem_req.block, ref_block(a));
                    mem_fresh[a] = 1'b1;
                end else begin
                    want = load_req.valid ? int'(load_req.address.block.block_addr)
                                          : int'(store_req.address.block.block_addr);
                    assert (a == want) else wrong_value("mem_req.block_addr", a, want);
                    // each accepted read takes the next slot of the circular MSHR
                    if (load_resp.valid) begin
                        assert (load_resp.mask == '0)
                            else wrong_value("load_resp.mask", load_resp.mask, 0);
                        assert (load_resp.mshr_idx == next_alloc)
                            else wrong_value("load_resp.mshr_idx", load_resp.mshr_idx, next_alloc);
                    end else begin
                        assert (store_accepted)
                            else abort_run("memory read accepted with no request served");
                    end
                    pend_idx.push_back(next_alloc);
                    pend_addr.push_back(a);
                    next_alloc = next_alloc + 1'b1;
                end
            end
            if (load_resp.valid) begin
                verify_load();
                last_mask = load_resp.mask;
            end
            if (fill.valid) begin
                verify_fill();
            end
            if (load_resp.valid || store_accepted) begin
                op_done = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        dcache_addr_t addr;
        word_t        data;
        byte_mask_t   mask;
        logic         is_store;
        int           stale;
        reset      = 1'b1;
        op_done    = 1'b0;
        last_mask  = '0;
        next_alloc = '0;
        drive_idle();
        repeat (10) begin
            @(negedge clock);
            outputs_idle();
        end
        // reference starts from the memory image
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            mem_fresh[b] = 1'b1;
            for (int k = 0; k < BLOCK_BYTES; k++) begin
                ref_bytes[b][k] = mem.blocks[b][k/4][8*(k%4) +: 8];
            end
        end
        reset = 1'b0;
        @(negedge clock);
        outputs_idle();

        for (int op = 0; op < NUM_OPS; op++) begin
            repeat ($random(seed) & 3) @(negedge clock);
            addr                  = '0;
            addr.block.block_addr = block_addr_t'($random(seed) & 31);
            addr.block.word_idx   = $random(seed) & 1;
            is_store              = 1'($random(seed));
            data                  = $random(seed);
            mask                  = 4'($random(seed));
            if (mask == '0) begin
                mask = 4'hf;
            end
            run_op(is_store, addr, data, mask);
        end

        // drain by reading each block again until it comes back whole
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            addr                  = '0;
            addr.block.block_addr = block_addr_t'(b);
            do begin
                run_op(1'b0, addr, '0, '0);
            end while (last_mask != '1);
        end

        // a block with no store since its last write-back must match memory exactly
        stale = 0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            if (mem_fresh[b]) begin
                assert (mem.blocks[b] == ref_block(b))
                    else wrong_value($sformatf("mem.blocks[%0d]", b), mem.blocks[b],
                                     ref_block(b));
            end else if (mem.blocks[b] != ref_block(b)) begin
                stale++;
            end
        end
        assert (stale <= CACHED_MAX)
            else abort_run($sformatf("%0d memory blocks are out of date", stale));
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verif/dcache_mem_model.sv
// tagged main memory model with fixed read latency, random accept and in-order read data
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int NUM_BLOCKS = 32,
    parameter int LATENCY    = 12
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    output logic                  mem_accepted,
    output dcache_pkg::mem_tag_t  mem_tag,
    output dcache_pkg::mem_resp_t mem_resp
);
    import dcache_pkg::*;

    typedef struct packed {
        mem_tag_t    tag;
        block_t      block;
        logic [31:0] due;
    } read_t;

    block_t      blocks [NUM_BLOCKS];
    read_t       reads [$];
    logic [31:0] cycle;
    logic        accept_roll;
    mem_tag_t    next_tag;
    integer      seed;

    // every byte holds a value made from its full byte address
    initial begin
        seed        = 32'h5abc_f27d;
        accept_roll = 1'b0;
        next_tag    = mem_tag_t'(1);
        cycle       = '0;
        mem_resp    = '0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int k = 0; k < BLOCK_BYTES; k++) begin
                blocks[b][k/4][8*(k%4) +: 8] = 8'((8*b + k) * 37 + 11);
            end
        end
    end

    // fresh accept decision every cycle, 3 in 4
    always @(negedge clock) begin
        accept_roll <= ($random(seed) & 3) != 0;
    end

    assign mem_accepted = mem_req.valid && accept_roll;
    assign mem_tag      = next_tag;

    always @(posedge clock) begin
        read_t rd;
        if (reset) begin
            reads.delete();
            next_tag <= mem_tag_t'(1);
            cycle    <= '0;
            mem_resp <= '0;
        end else begin
            cycle <= cycle + 1;
            if (mem_accepted) begin
                if (mem_req.write) begin
                    blocks[int'(mem_req.block_addr)] <= mem_req.block;
                end else begin
                    // read data is fixed at the moment of accept
                    rd.tag   = next_tag;
                    rd.block = blocks[int'(mem_req.block_addr)];
                    rd.due   = cycle + LATENCY;
                    reads.push_back(rd);
                    next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
                end
            end
            if (reads.size() > 0 && reads[0].due <= cycle) begin
                mem_resp.tag   <= reads[0].tag;
                mem_resp.block <= reads[0].block;
                void'(reads.pop_front());
            end else begin
                mem_resp <= '0;
            end
        end
    end

endmodule

//--- hdl/dcache_top.sv
// dcache top level joining the controller, the tag/data array and the MSHR queue
`timescale 1ns/1ps

module dcache_top (
    input  logic                   clock,
    input  logic                   reset,
    input  dcache_pkg::load_req_t  load_req,
    input  dcache_pkg::store_req_t store_req,
    output dcache_pkg::load_resp_t load_resp,
    output logic                   store_accepted,
    output dcache_pkg::fill_t      fill,
    output dcache_pkg::mem_req_t   mem_req,
    input  logic                   mem_accepted,
    input  dcache_pkg::mem_tag_t   mem_tag,
    input  dcache_pkg::mem_resp_t  mem_resp
);
    import dcache_pkg::*;

    // array lookup and victim
    logic         load_hit;
    block_t       load_block;
    logic         store_hit;
    logic         victim_dirty;
    dcache_addr_t victim_addr;
    block_t       victim_block;

    // MSHR lookup and retirement
    logic         mshr_load_hit;
    mshr_idx_t    mshr_load_idx;
    block_t       mshr_load_block;
    block_mask_t  mshr_load_mask;
    logic         mshr_store_hit;
    logic         mshr_full;
    logic         retire_valid;
    mshr_entry_t  retire_entry;
    mshr_idx_t    alloc_idx;

    // controller decisions
    logic         store_write;
    logic         load_touch;
    logic         mshr_store_merge;
    logic         mshr_alloc;
    dcache_addr_t alloc_addr;
    logic         alloc_is_store;
    logic         install;

    dcache_ctrl ctrl (.*);

    dcache_array array (
        .load_addr    (load_req.address),
        .install_entry(retire_entry),
        .*
    );

    mshr_queue mshrs (
        .load_addr(load_req.address),
        .*
    );

endmodule

//--- hdl/mshr_queue.sv
// MSHR queue with address CAM, store merge, in-order fill and in-order retirement
`timescale 1ns/1ps
`include "dcache_settings.svh"

module mshr_queue (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::dcache_addr_t load_addr,
    input  dcache_pkg::store_req_t   store_req,
    input  logic                     mshr_store_merge,
    input  logic                     mshr_alloc,
    input  dcache_pkg::dcache_addr_t alloc_addr,
    input  logic                     alloc_is_store,
    input  dcache_pkg::mem_tag_t     mem_tag,
    input  dcache_pkg::mem_resp_t    mem_resp,
    input  logic                     install,
    output logic                     mshr_load_hit,
    output dcache_pkg::mshr_idx_t    mshr_load_idx,
    output dcache_pkg::block_t       mshr_load_block,
    output dcache_pkg::block_mask_t  mshr_load_mask,
    output logic                     mshr_store_hit,
    output logic                     mshr_full,
    output dcache_pkg::fill_t        fill,
    output logic                     retire_valid,
    output dcache_pkg::mshr_entry_t  retire_entry,
    output dcache_pkg::mshr_idx_t    alloc_idx
);
    import dcache_pkg::*;

    localparam int DEPTH = `DCACHE_MSHR_DEPTH;
    localparam int CNT_W = `DCACHE_MSHR_IDX_BITS + 1;

    mshr_entry_t      entries      [DEPTH];
    mshr_entry_t      next_entries [DEPTH];
    mshr_idx_t        tail;
    mshr_idx_t        head;
    mshr_idx_t        rhead;
    mshr_idx_t        store_idx;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] unfilled;
    logic             fill_fire;

    function automatic mshr_entry_t merge_store(mshr_entry_t e, store_req_t st);
        logic [`DCACHE_WORD_IDX_BITS-1:0] w;
        w = st.address.block.word_idx;
        for (int b = 0; b < 4; b++) begin
            if (st.mask[b]) begin
                e.block[w][8*b +: 8] = st.data[8*b +: 8];
                e.mask[4*w + b]      = 1'b1;
            end
        end
        e.dirty = 1'b1;
        return e;
    endfunction

    // search live entries oldest first from the retire head
    always_comb begin
        mshr_idx_t slot;
        mshr_load_hit  = 1'b0;
        mshr_load_idx  = '0;
        mshr_store_hit = 1'b0;
        store_idx      = '0;
        for (int i = 0; i < DEPTH; i++) begin
            slot = rhead + mshr_idx_t'(i);
            if (CNT_W'(i) < count) begin
                if (entries[slot].block_addr == load_addr.block.block_addr) begin
                    mshr_load_hit = 1'b1;
                    mshr_load_idx = slot;
                end
                if (entries[slot].block_addr == store_req.address.block.block_addr) begin
                    mshr_store_hit = 1'b1;
                    store_idx      = slot;
                end
            end
        end
    end

    assign mshr_load_block = entries[mshr_load_idx].block;
    assign mshr_load_mask  = entries[mshr_load_idx].mask;

    // responses come back in request order
    assign fill_fire = mem_resp.tag != '0 && mem_resp.tag == entries[head].mem_tag;

    always_comb begin
        next_entries = entries;
        if (mshr_store_merge) begin
            next_entries[store_idx] = merge_store(entries[store_idx], store_req);
        end
        if (mshr_alloc) begin
            next_entries[tail]            = '0;
            next_entries[tail].block_addr = alloc_addr.block.block_addr;
            next_entries[tail].mem_tag    = mem_tag;
            if (alloc_is_store) begin
                next_entries[tail] = merge_store(next_entries[tail], store_req);
            end
        end
        // memory bytes only where no store has landed
        if (fill_fire) begin
            for (int k = 0; k < BLOCK_BYTES; k++) begin
                if (!next_entries[head].mask[k]) begin
                    next_entries[head].block[k/4][8*(k%4) +: 8] =
                        mem_resp.block[k/4][8*(k%4) +: 8];
                end
            end
            next_entries[head].mask = '1;
        end
    end

    assign fill         = '{valid: fill_fire, mshr_idx: head, block: next_entries[head].block};
    assign retire_valid = count != unfilled;
    assign retire_entry = entries[rhead];
    assign mshr_full    = count == CNT_W'(DEPTH);
    assign alloc_idx    = tail;

    always_ff @(posedge clock) begin
        if (reset) begin
            tail     <= '0;
            head     <= '0;
            rhead    <= '0;
            count    <= '0;
            unfilled <= '0;
        end else begin
            tail     <= tail + mshr_idx_t'(mshr_alloc);
            head     <= head + mshr_idx_t'(fill_fire);
            rhead    <= rhead + mshr_idx_t'(install);
            count    <= count + CNT_W'(mshr_alloc) - CNT_W'(install);
            unfilled <= unfilled + CNT_W'(mshr_alloc) - CNT_W'(fill_fire);
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

    assert property (@(posedge clock) disable iff (reset) count <= CNT_W'(DEPTH));

    // every matching response belongs to an entry still waiting for data
    assert property (@(posedge clock) disable iff (reset) fill_fire |-> unfilled != '0);

endmodule

//--- hdl/dcache_array.sv
// dcache tag and data array with 2-way lookup, LRU, store-hit write and install
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_array (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::dcache_addr_t load_addr,
    input  dcache_pkg::store_req_t   store_req,
    input  logic                     load_touch,
    input  logic                     store_write,
    input  logic                     install,
    input  dcache_pkg::mshr_entry_t  install_entry,
    output logic                     load_hit,
    output dcache_pkg::block_t       load_block,
    output logic                     store_hit,
    output logic                     victim_dirty,
    output dcache_pkg::dcache_addr_t victim_addr,
    output dcache_pkg::block_t       victim_block
);
    import dcache_pkg::*;

    localparam int SETS  = `DCACHE_NUM_SETS;
    localparam int WAYS  = `DCACHE_NUM_WAYS;
    localparam int SET_W = `DCACHE_SET_IDX_BITS;
    localparam int WAY_W = `DCACHE_WAY_IDX_BITS;

    line_meta_t [SETS-1:0][WAYS-1:0] meta;
    block_t                          data [SETS][WAYS];

    dcache_addr_t ins_addr;
    logic [SET_W-1:0] load_set;
    logic [SET_W-1:0] store_set;
    logic [SET_W-1:0] touch_set;
    logic [WAY_W-1:0] load_way;
    logic [WAY_W-1:0] store_way;
    logic [WAY_W-1:0] victim_way;
    logic [WAY_W-1:0] touch_way;

    // retiring block seen through the cache view
    always_comb begin
        ins_addr                  = '0;
        ins_addr.block.block_addr = install_entry.block_addr;
    end

    assign load_set  = load_addr.cache.set_idx;
    assign store_set = store_req.address.cache.set_idx;

    ////////////////////
    // tag compare

    always_comb begin
        load_hit  = 1'b0;
        load_way  = '0;
        store_hit = 1'b0;
        store_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (meta[load_set][w].valid && meta[load_set][w].tag == load_addr.cache.tag) begin
                load_hit = 1'b1;
                load_way = WAY_W'(w);
            end
            if (meta[store_set][w].valid &&
                meta[store_set][w].tag == store_req.address.cache.tag) begin
                store_hit = 1'b1;
                store_way = WAY_W'(w);
            end
        end
    end

    assign load_block = data[load_set][load_way];

    // victim is the way marked least recent
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (meta[ins_addr.cache.set_idx][w].lru) begin
                victim_way = WAY_W'(w);
            end
        end
    end

    assign victim_dirty = meta[ins_addr.cache.set_idx][victim_way].valid
                          && meta[ins_addr.cache.set_idx][victim_way].dirty;
    assign victim_block = data[ins_addr.cache.set_idx][victim_way];

    always_comb begin
        victim_addr               = '0;
        victim_addr.cache.tag     = meta[ins_addr.cache.set_idx][victim_way].tag;
        victim_addr.cache.set_idx = ins_addr.cache.set_idx;
    end

    // way being used this cycle becomes most recent
    always_comb begin
        touch_set = ins_addr.cache.set_idx;
        touch_way = victim_way;
        if (store_write) begin
            touch_set = store_set;
            touch_way = store_way;
        end else if (load_touch) begin
            touch_set = load_set;
            touch_way = load_way;
        end
    end

    ////////////////////
    // state update

    always_ff @(posedge clock) begin
        if (reset) begin
            meta <= '0;
        end else begin
            if (install || store_write || load_touch) begin
                for (int w = 0; w < WAYS; w++) begin
                    meta[touch_set][w].lru <= (WAY_W'(w) != touch_way);
                end
            end
            if (store_write) begin
                meta[store_set][store_way].dirty <= 1'b1;
            end
            if (install) begin
                meta[ins_addr.cache.set_idx][victim_way].valid <= 1'b1;
                meta[ins_addr.cache.set_idx][victim_way].dirty <= install_entry.dirty;
                meta[ins_addr.cache.set_idx][victim_way].tag   <= ins_addr.cache.tag;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (install) begin
            data[ins_addr.cache.set_idx][victim_way] <= install_entry.block;
        end else if (store_write) begin
            for (int b = 0; b < 4; b++) begin
                if (store_req.mask[b]) begin
                    data[store_set][store_way][store_req.address.cache.word_idx][8*b +: 8]
                        <= store_req.data[8*b +: 8];
                end
            end
        end
    end

    // MSHR CAM keeps a block from being installed twice
    for (genvar s = 0; s < SETS; s++) begin : g_tag_check
        assert property (@(posedge clock) disable iff (reset)
            !(meta[s][0].valid && meta[s][1].valid && meta[s][0].tag == meta[s][1].tag));
    end

endmodule

//--- hdl/dcache_ctrl.sv
// dcache controller for hit priority, miss allocation, install and the memory port
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::load_req_t    load_req,
    input  dcache_pkg::store_req_t   store_req,
    input  logic                     mem_accepted,
    input  logic                     load_hit,
    input  dcache_pkg::block_t       load_block,
    input  logic                     store_hit,
    input  logic                     victim_dirty,
    input  dcache_pkg::dcache_addr_t victim_addr,
    input  dcache_pkg::block_t       victim_block,
    input  logic                     mshr_load_hit,
    input  dcache_pkg::mshr_idx_t    mshr_load_idx,
    input  dcache_pkg::block_t       mshr_load_block,
    input  dcache_pkg::block_mask_t  mshr_load_mask,
    input  logic                     mshr_store_hit,
    input  logic                     mshr_full,
    input  logic                     retire_valid,
    input  dcache_pkg::mshr_idx_t    alloc_idx,
    output logic                     store_write,
    output logic                     load_touch,
    output logic                     mshr_store_merge,
    output logic                     mshr_alloc,
    output dcache_pkg::dcache_addr_t alloc_addr,
    output logic                     alloc_is_store,
    output logic                     install,
    output dcache_pkg::load_resp_t   load_resp,
    output logic                     store_accepted,
    output dcache_pkg::mem_req_t     mem_req
);

    logic sel_load_mshr;
    logic sel_store_mshr;
    logic sel_load_arr;
    logic sel_store_arr;
    logic miss_req;
    logic install_base;
    logic evict_req;

    // one request served per cycle, MSHR hits first
    assign sel_load_mshr  = load_req.valid && mshr_load_hit;
    assign sel_store_mshr = !sel_load_mshr && store_req.valid && mshr_store_hit;
    assign sel_load_arr   = !sel_load_mshr && !sel_store_mshr && load_req.valid && load_hit;
    assign sel_store_arr  = !sel_load_mshr && !sel_store_mshr && !sel_load_arr
                            && store_req.valid && store_hit;

    // a load takes the miss slot before a store
    assign miss_req = !(sel_load_mshr || sel_store_mshr || sel_load_arr || sel_store_arr)
                      && (load_req.valid || store_req.valid) && !mshr_full;
    assign alloc_is_store = !load_req.valid;
    assign alloc_addr     = load_req.valid ? load_req.address : store_req.address;
    assign mshr_alloc     = miss_req && mem_accepted;

    assign store_write      = sel_store_arr;
    assign load_touch       = sel_load_arr;
    assign mshr_store_merge = sel_store_mshr;
    assign store_accepted   = sel_store_mshr || sel_store_arr || (mshr_alloc && alloc_is_store);

    ////////////////////
    // install of the oldest filled entry

    // array must be idle; a dirty victim also needs the memory port
    assign install_base = retire_valid && !sel_load_arr && !sel_store_arr && !sel_store_mshr;
    assign evict_req    = install_base && victim_dirty && !miss_req;
    assign install      = install_base && (victim_dirty ? evict_req && mem_accepted : !mshr_alloc);

    // miss read wins the port over the eviction write
    always_comb begin
        mem_req = '0;
        if (miss_req) begin
            mem_req.valid      = 1'b1;
            mem_req.block_addr = alloc_addr.block.block_addr;
        end else if (evict_req) begin
            mem_req.valid      = 1'b1;
            mem_req.write      = 1'b1;
            mem_req.block_addr = victim_addr.block.block_addr;
            mem_req.block      = victim_block;
        end
    end

    always_comb begin
        load_resp = '0;
        if (sel_load_mshr) begin
            load_resp.valid    = 1'b1;
            load_resp.mshr_idx = mshr_load_idx;
            load_resp.mask     = mshr_load_mask;
            load_resp.block    = mshr_load_block;
        end else if (sel_load_arr) begin
            load_resp.valid = 1'b1;
            load_resp.mask  = '1;
            load_resp.block = load_block;
        end else if (mshr_alloc && !alloc_is_store) begin
            // nothing known yet for a fresh load miss
            load_resp.valid    = 1'b1;
            load_resp.mshr_idx = alloc_idx;
        end
    end

    // array write, MSHR merge, allocation and install never share a cycle
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({store_write, mshr_store_merge, mshr_alloc, install}));

endmodule

//--- hdl/dcache_pkg.sv
// dcache types for address views, port packets, MSHR entries and line metadata
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int BLOCK_BYTES     = 4 * `DCACHE_WORDS_PER_BLOCK;
    localparam int BLOCK_ADDR_BITS = `DCACHE_ADDR_BITS - `DCACHE_WORD_IDX_BITS - 2;
    localparam int TAG_BITS        = BLOCK_ADDR_BITS - `DCACHE_SET_IDX_BITS;

    typedef logic [31:0]                         word_t;
    typedef word_t [`DCACHE_WORDS_PER_BLOCK-1:0] block_t;
    typedef logic [3:0]                          byte_mask_t;
    typedef logic [BLOCK_BYTES-1:0]              block_mask_t;
    typedef logic [`DCACHE_MEM_TAG_BITS-1:0]     mem_tag_t;
    typedef logic [`DCACHE_MSHR_IDX_BITS-1:0]    mshr_idx_t;
    typedef logic [BLOCK_ADDR_BITS-1:0]          block_addr_t;

    ////////////////////
    // one address, two decodes

    typedef struct packed {
        logic [TAG_BITS-1:0]              tag;
        logic [`DCACHE_SET_IDX_BITS-1:0]  set_idx;
        logic [`DCACHE_WORD_IDX_BITS-1:0] word_idx;
        logic [1:0]                       byte_off;
    } cache_view_t;

    typedef struct packed {
        block_addr_t                      block_addr;
        logic [`DCACHE_WORD_IDX_BITS-1:0] word_idx;
        logic [1:0]                       byte_off;
    } block_view_t;

    typedef union packed {
        cache_view_t cache;
        block_view_t block;
    } dcache_addr_t;

    ////////////////////
    // port packets

    typedef struct packed {
        logic         valid;
        dcache_addr_t address;
    } load_req_t;

    typedef struct packed {
        logic         valid;
        dcache_addr_t address;
        word_t        data;
        byte_mask_t   mask;
    } store_req_t;

    // full mask means the block is not pending
    typedef struct packed {
        logic        valid;
        mshr_idx_t   mshr_idx;
        block_mask_t mask;
        block_t      block;
    } load_resp_t;

    typedef struct packed {
        logic      valid;
        mshr_idx_t mshr_idx;
        block_t    block;
    } fill_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        block_addr_t block_addr;
        block_t      block;
    } mem_req_t;

    // tag 0 carries nothing
    typedef struct packed {
        mem_tag_t tag;
        block_t   block;
    } mem_resp_t;

    ////////////////////
    // internal state

    typedef struct packed {
        block_addr_t block_addr;
        block_t      block;
        block_mask_t mask;
        logic        dirty;
        mem_tag_t    mem_tag;
    } mshr_entry_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
        logic                lru;
    } line_meta_t;

endpackage

//--- hdl/dcache_settings.svh
// data cache settings for geometry, MSHR depth and memory tag width
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address and block geometry
`define DCACHE_ADDR_BITS       16
`define DCACHE_WORDS_PER_BLOCK 2
`define DCACHE_NUM_SETS        4
`define DCACHE_NUM_WAYS        2

// outstanding misses and memory transaction tags
`define DCACHE_MSHR_DEPTH      4
`define DCACHE_MEM_TAG_BITS    4

// derived index widths
`define DCACHE_WORD_IDX_BITS   $clog2(`DCACHE_WORDS_PER_BLOCK)
`define DCACHE_SET_IDX_BITS    $clog2(`DCACHE_NUM_SETS)
`define DCACHE_WAY_IDX_BITS    $clog2(`DCACHE_NUM_WAYS)
`define DCACHE_MSHR_IDX_BITS   $clog2(`DCACHE_MSHR_DEPTH)

`endif
